// File: bench/edge_stim.txt
// edge engine stimulus, hex, one pixel per word
// first four data lines: source image rows 0 to 3, six pixels each
// last three data lines: expected roberts rows 1 to 3, five pixels each
// result = |tl - br| + |tr - bl|, clipped at ff
00 10 20 ff 80 40   // image row 0
ff 00 30 20 00 ff   // image row 1
10 10 10 10 10 10   // image row 2, flat
00 ff 00 ff 80 08   // image row 3
ef 40 cf ff bf      // result row 1, column 3 clips from 15f
ff 30 30 20 ff      // result row 2, ef + 10 lands on ff exactly
ff ff ff ff 78      // result row 3, column 3 clips from 15f

// File: build.f
src/img_pkg.sv
src/ctrl_pkg.sv
src/seq_ctrl.sv
src/scan_counters.sv
src/addr_gen.sv
src/roberts_window.sv
src/line_ram.sv
src/edge_top.sv
bench/edge_props.sv
bench/tb_checker.sv
bench/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the edge engine testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_top -f build.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
echo "pass message not found"
exit 1

// File: bench/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

import img_pkg::*;

localparam int IMG_W = 6;
localparam int IMG_H = 4;
localparam sdram_addr_t OUT_BASE = 16'h0100;
localparam int RUNS = 2;                          // second run sees other read latencies
localparam int N_PIX = IMG_W * IMG_H;
localparam int N_RES = (IMG_W - 1) * (IMG_H - 1);
// worst case cycles for all runs, plus reset and idle gaps
localparam int LIMIT = 2 * RUNS * (N_PIX * (4 + 3) + N_RES * 3) + 100;

logic clk;
logic n_rst;
logic start;
logic finish;
logic sdram_rd;
logic sdram_wr;
sdram_addr_t sdram_addr;
pix_t sdram_wdata;
pix_t sdram_rdata = '0;
logic sdram_valid = 1'b0;
int err_cnt;                    // from checker
int chk_cnt;

pix_t stim_mem [N_PIX + N_RES]; // image served by the sdram model
logic [7:0] lfsr = 8'd75;       // latency source
logic rd_pending = 1'b0;        // read accepted, answer still due
int rd_addr = 0;
int wait_left = 0;              // cycles before the answer

edge_top #(.IMG_W(IMG_W), .IMG_H(IMG_H), .OUT_BASE(OUT_BASE)) u_dut (
	.clk(clk), .n_rst(n_rst), .start_i(start), .finish_o(finish),
	.sdram_rd_o(sdram_rd), .sdram_wr_o(sdram_wr), .sdram_addr_o(sdram_addr),
	.sdram_wdata_o(sdram_wdata), .sdram_rdata_i(sdram_rdata), .sdram_valid_i(sdram_valid)
);

tb_checker #(.IMG_W(IMG_W), .IMG_H(IMG_H), .OUT_BASE(OUT_BASE)) u_chk (
	.clk(clk), .n_rst(n_rst), .start_i(start), .rd_i(sdram_rd), .wr_i(sdram_wr),
	.addr_i(sdram_addr), .wdata_i(sdram_wdata), .finish_i(finish),
	.err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt)
);

// galois form, x^8 + x^6 + x^5 + x^4 + 1
function automatic logic [7:0] lfsr_next(input logic [7:0] s);
	return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
endfunction

task automatic take_latency(output int lat);
	lat = 1;
	for (int i = 0; i < 2; i++)
	begin
		if (lfsr[0])
			lat = lat + (1 << i);       // bit shifted out this step
		lfsr = lfsr_next(lfsr);
	end
endtask

initial
begin
	clk = 1'b0;
	forever #4 clk = ~clk;              // 8 ns period
end

// sdram model, answers one read at a time after 1 to 4 cycles
always @(posedge clk)
begin
	int lat;
	sdram_valid <= 1'b0;
	if (sdram_rd)
	begin
		take_latency(lat);
		if (lat == 1)
		begin
			sdram_valid <= 1'b1;        // answer in the very next cycle
			sdram_rdata <= stim_mem[int'(sdram_addr)];
		end
		else
		begin
			rd_pending <= 1'b1;
			rd_addr <= int'(sdram_addr);
			wait_left <= lat - 2;
		end
	end
	else if (rd_pending)
	begin
		if (wait_left == 0)
		begin
			sdram_valid <= 1'b1;
			sdram_rdata <= stim_mem[rd_addr];
			rd_pending <= 1'b0;
		end
		else
			wait_left <= wait_left - 1;
	end
end

initial
begin
	n_rst = 1'b0;
	start = 1'b0;
	$readmemh("bench/edge_stim.txt", stim_mem);
	repeat (4) @(posedge clk);
	n_rst <= 1'b1;
	repeat (6) @(posedge clk);          // quiet window before the first start
	for (int run = 0; run < RUNS; run++)
	begin
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (finish !== 1'b1)
			@(posedge clk);
		repeat (5) @(posedge clk);      // engine must stay idle here
	end
	@(negedge clk);
	$display("checks: %0d  checker errors: %0d  assertion failures: %0d",
		chk_cnt, err_cnt, u_dut.u_seq.u_props.fail_cnt);
	if (err_cnt == 0 && u_dut.u_seq.u_props.fail_cnt == 0)
		$display("ALL TESTS PASSED");
	else
		$display("SOME TESTS FAILED");
	$finish;
end

// watchdog
initial
begin
	repeat (LIMIT) @(posedge clk);
	$display("timeout: the runs did not complete within %0d cycles", LIMIT);
	$display("SOME TESTS FAILED");
	$finish;
end

endmodule

`default_nettype wire

// File: bench/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker
#(
	parameter int IMG_W = 6,
	parameter int IMG_H = 4,
	parameter img_pkg::sdram_addr_t OUT_BASE = 16'h0100
)
(
	input wire clk,
	input wire n_rst,
	input wire start_i,
	input wire rd_i,
	input wire wr_i,
	input wire img_pkg::sdram_addr_t addr_i,
	input wire img_pkg::pix_t wdata_i,
	input wire finish_i,
	output int err_cnt_o,
	output int chk_cnt_o
);

import img_pkg::*;

localparam int N_PIX = IMG_W * IMG_H;             // each source pixel read once
localparam int N_RES = (IMG_W - 1) * (IMG_H - 1); // each result written once

pix_t stim [N_PIX + N_RES];     // image, then expected results
logic busy = 1'b0;              // between start and finish
int run = 0;
int rd_seen = 0;
int wr_seen = 0;
int err_cnt = 0;
int chk_cnt = 0;

assign err_cnt_o = err_cnt;
assign chk_cnt_o = chk_cnt;

initial
	$readmemh("bench/edge_stim.txt", stim);

task automatic check_value(input string name, input int expected, input int actual);
	chk_cnt++;
	if (expected != actual)
	begin
		$display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
		err_cnt++;
	end
endtask

task automatic report_problem(input string what);
	$display("run %0d: %s", run, what);
	err_cnt++;
endtask

always @(posedge clk)
begin
	int r;
	int c;
	if (n_rst !== 1'b1)
		busy = 1'b0;
	else if (!busy)
	begin
		if (rd_i || wr_i || finish_i)
			report_problem("sdram access or finish_o while the engine is idle");
		if (start_i)
		begin
			busy = 1'b1;
			run++;
			rd_seen = 0;
			wr_seen = 0;
		end
	end
	else
	begin
		if (rd_i)
		begin
			if (rd_seen >= N_PIX)
				report_problem("more image reads than image pixels");
			else
			begin
				r = rd_seen / IMG_W;            // row-major scan
				c = rd_seen % IMG_W;
				check_value($sformatf("run %0d read r%0d c%0d address", run, r, c),
					r * IMG_W + c, int'(addr_i));
			end
			rd_seen++;
		end
		if (wr_i)
		begin
			if (wr_seen >= N_RES)
				report_problem("more result writes than result pixels");
			else
			begin
				r = wr_seen / (IMG_W - 1) + 1;  // image row 0 gives no result
				c = wr_seen % (IMG_W - 1);
				check_value($sformatf("run %0d result r%0d c%0d address", run, r, c),
					int'(OUT_BASE) + (r - 1) * (IMG_W - 1) + c, int'(addr_i));
				check_value($sformatf("run %0d result r%0d c%0d pixel", run, r, c),
					int'(stim[N_PIX + wr_seen]), int'(wdata_i));
			end
			wr_seen++;
		end
		if (finish_i)
		begin
			check_value($sformatf("run %0d reads before finish", run), N_PIX, rd_seen);
			check_value($sformatf("run %0d writes before finish", run), N_RES, wr_seen);
			busy = 1'b0;                        // a longer pulse shows up as idle activity
		end
	end
end

endmodule

`default_nettype wire

// File: bench/edge_props.sv
`timescale 1ns/1ps
`default_nettype none

module edge_props
(
	input wire clk,
	input wire n_rst,
	input wire rd_i,
	input wire wr_i,
	input wire valid_i,
	input wire finish_i
);

int fail_cnt = 0;       // summed into the closing count line
logic rd_open;          // read issued, data not yet back

always_ff @(posedge clk, negedge n_rst)
begin
	if (n_rst == 1'b0)
		rd_open <= 1'b0;
	else if (rd_i)
		rd_open <= 1'b1;
	else if (valid_i)
		rd_open <= 1'b0;
end

rd_wr_exclusive: assert property (@(posedge clk) disable iff (!n_rst) !(rd_i && wr_i))
else
begin
	$error("sdram read and write in the same cycle");
	fail_cnt++;
end

rd_one_cycle: assert property (@(posedge clk) disable iff (!n_rst) rd_i |=> !rd_i)
else
begin
	$error("sdram_rd_o high for more than one cycle");
	fail_cnt++;
end

rd_single_outstanding: assert property (@(posedge clk) disable iff (!n_rst) rd_open |-> !rd_i)
else
begin
	$error("new sdram read while one is outstanding");
	fail_cnt++;
end

finish_one_cycle: assert property (@(posedge clk) disable iff (!n_rst) finish_i |=> !finish_i)
else
begin
	$error("finish_o high for more than one cycle");
	fail_cnt++;
end

endmodule

bind seq_ctrl edge_props u_props (
	.clk(clk), .n_rst(n_rst), .rd_i(sdram_rd_o), .wr_i(sdram_wr_o),
	.valid_i(sdram_valid_i), .finish_i(finish_o)
);

`default_nettype wire

// File: src/edge_top.sv
`timescale 1ns/1ps
`default_nettype none

module edge_top
#(
	parameter int IMG_W = 6,
	parameter int IMG_H = 4,
	parameter img_pkg::sdram_addr_t OUT_BASE = 16'h0100
)
(
	input wire clk,
	input wire n_rst,
	input wire start_i,
	output logic finish_o,
	output logic sdram_rd_o,
	output logic sdram_wr_o,
	output img_pkg::sdram_addr_t sdram_addr_o,
	output img_pkg::pix_t sdram_wdata_o,
	input wire img_pkg::pix_t sdram_rdata_i,
	input wire sdram_valid_i
);

import img_pkg::*;
import ctrl_pkg::*;

localparam int COL_W = $clog2(IMG_W);
localparam int ROW_W = $clog2(IMG_H);
localparam int RAM_AW = $clog2(2 * IMG_W - 1);

logic cnt_clr;                  // restart all counters
logic col_inc;
logic row_inc;
logic out_inc;
logic [COL_W-1:0] col;          // image column
logic [ROW_W-1:0] row;          // image row
logic [COL_W-1:0] out_col;      // result column in write-back
logic col_last;
logic row_last;
logic out_last;
sdram_dir_e sdram_dir;
logic ram_en;
logic ram_we;
ram_region_e ram_region;
logic [RAM_AW-1:0] ram_addr;
logic ram_valid;
logic wb_en;
wb_mode_e wb_mode;
pix_t grad;                     // roberts value of current window

seq_ctrl u_seq (
	.clk(clk), .n_rst(n_rst), .start_i(start_i),
	.sdram_valid_i(sdram_valid_i), .ram_valid_i(ram_valid),
	.col_last_i(col_last), .row_last_i(row_last), .out_last_i(out_last),
	.finish_o(finish_o), .sdram_rd_o(sdram_rd_o), .sdram_wr_o(sdram_wr_o),
	.cnt_clr_o(cnt_clr), .col_inc_o(col_inc), .row_inc_o(row_inc), .out_inc_o(out_inc),
	.sdram_dir_o(sdram_dir),
	.ram_en_o(ram_en), .ram_we_o(ram_we), .ram_region_o(ram_region),
	.wb_en_o(wb_en), .wb_mode_o(wb_mode)
);

scan_counters #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_cnt (
	.clk(clk), .n_rst(n_rst), .cnt_clr_i(cnt_clr),
	.col_inc_i(col_inc), .row_inc_i(row_inc), .out_inc_i(out_inc),
	.col_o(col), .row_o(row), .out_col_o(out_col),
	.col_last_o(col_last), .row_last_o(row_last), .out_last_o(out_last)
);

addr_gen #(.IMG_W(IMG_W), .IMG_H(IMG_H), .OUT_BASE(OUT_BASE)) u_addr (
	.col_i(col), .row_i(row), .out_col_i(out_col),
	.sdram_dir_i(sdram_dir), .ram_region_i(ram_region),
	.sdram_addr_o(sdram_addr_o), .ram_addr_o(ram_addr)
);

roberts_window u_win (
	.clk(clk), .n_rst(n_rst), .wb_en_i(wb_en), .wb_mode_i(wb_mode),
	.ram_pix_i(sdram_wdata_o), .sdram_pix_i(sdram_rdata_i), // ram read data doubles as write data
	.grad_o(grad)
);

line_ram #(.IMG_W(IMG_W)) u_ram (
	.clk(clk), .n_rst(n_rst), .en_i(ram_en), .we_i(ram_we),
	.region_i(ram_region), .addr_i(ram_addr),
	.cache_wdata_i(sdram_rdata_i), .grad_wdata_i(grad),
	.rdata_o(sdram_wdata_o), .valid_o(ram_valid)
);

endmodule

`default_nettype wire

// File: src/line_ram.sv
`timescale 1ns/1ps
`default_nettype none

module line_ram
#(
	parameter int IMG_W = 6
)
(
	input wire clk,
	input wire n_rst,
	input wire en_i,
	input wire we_i,
	input wire ctrl_pkg::ram_region_e region_i,
	input wire [$clog2(2*IMG_W-1)-1:0] addr_i,
	input wire img_pkg::pix_t cache_wdata_i,
	input wire img_pkg::pix_t grad_wdata_i,
	output img_pkg::pix_t rdata_o,
	output logic valid_o
);

import img_pkg::*;
import ctrl_pkg::*;

localparam int DEPTH = 2 * IMG_W - 1;  // full cache row plus result row

pix_t mem [DEPTH];      // 0..W-1 cache, W..2W-2 output row
pix_t wdata;

assign wdata = (region_i == ROW_CACHE) ? cache_wdata_i : grad_wdata_i;

always_ff @(posedge clk)
begin
	if (en_i && we_i)
		mem[addr_i] <= wdata;
	else if (en_i)
		rdata_o <= mem[addr_i];   // held until the next read
end

always_ff @(posedge clk, negedge n_rst)
begin
	if (n_rst == 1'b0)
		valid_o <= 1'b0;
	else
		valid_o <= en_i && !we_i; // read data ready one cycle on
end

endmodule

`default_nettype wire

// File: src/roberts_window.sv
`timescale 1ns/1ps
`default_nettype none

module roberts_window
(
	input wire clk,
	input wire n_rst,
	input wire wb_en_i,
	input wire ctrl_pkg::wb_mode_e wb_mode_i,
	input wire img_pkg::pix_t ram_pix_i,
	input wire img_pkg::pix_t sdram_pix_i,
	output img_pkg::pix_t grad_o
);

import img_pkg::*;
import ctrl_pkg::*;

pix_t tl;               // previous row, left
pix_t tr;               // previous row, right
pix_t bl;               // current row, left
pix_t br;               // current row, right
pix_t diag_a;           // |tl - br|
pix_t diag_b;           // |tr - bl|
logic [PIX_W:0] sum;    // carry marks overflow

always_ff @(posedge clk, negedge n_rst)
begin
	if (n_rst == 1'b0)
	begin
		tl <= '0;
		tr <= '0;
		bl <= '0;
		br <= '0;
	end
	else if (wb_en_i)
	begin
		case (wb_mode_i)
			LD_TL: tl <= ram_pix_i;
			LD_TR: tr <= ram_pix_i;
			LD_BL: bl <= sdram_pix_i;
			LD_BR: br <= sdram_pix_i;
			SHIFT:
			begin
				tl <= tr;   // window moves one column right
				bl <= br;
			end
			default: tl <= tl;  // unused codes hold
		endcase
	end
end

always_comb
begin
	diag_a = (tl > br) ? tl - br : br - tl;
	diag_b = (tr > bl) ? tr - bl : bl - tr;
	sum = {1'b0, diag_a} + {1'b0, diag_b};
	grad_o = sum[PIX_W] ? PIX_MAX : sum[PIX_W-1:0]; // clip to white
end

endmodule

`default_nettype wire

// File: src/addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module addr_gen
#(
	parameter int IMG_W = 6,
	parameter int IMG_H = 4,
	parameter img_pkg::sdram_addr_t OUT_BASE = 16'h0100
)
(
	input wire [$clog2(IMG_W)-1:0] col_i,
	input wire [$clog2(IMG_H)-1:0] row_i,
	input wire [$clog2(IMG_W)-1:0] out_col_i,
	input wire ctrl_pkg::sdram_dir_e sdram_dir_i,
	input wire ctrl_pkg::ram_region_e ram_region_i,
	output img_pkg::sdram_addr_t sdram_addr_o,
	output logic [$clog2(2*IMG_W-1)-1:0] ram_addr_o
);

import img_pkg::*;
import ctrl_pkg::*;

localparam int RAM_AW = $clog2(2 * IMG_W - 1);
localparam sdram_addr_t IN_PITCH = sdram_addr_t'(IMG_W);      // source row length
localparam sdram_addr_t OUT_PITCH = sdram_addr_t'(IMG_W - 1); // result row length
localparam logic [RAM_AW-1:0] OUT_OFS = RAM_AW'(IMG_W);       // output row follows cache

always_comb
begin
	if (sdram_dir_i == RD_IMAGE)
		sdram_addr_o = sdram_addr_t'(row_i) * IN_PITCH + sdram_addr_t'(col_i);
	else
		sdram_addr_o = OUT_BASE + (sdram_addr_t'(row_i) - 1'b1) * OUT_PITCH
			+ sdram_addr_t'(out_col_i);   // row 0 yields no result
end

always_comb
begin
	if (ram_region_i == ROW_CACHE)
		ram_addr_o = RAM_AW'(col_i);
	else if (sdram_dir_i == WR_RESULT)
		ram_addr_o = OUT_OFS + RAM_AW'(out_col_i);      // write-back read
	else
		ram_addr_o = OUT_OFS + RAM_AW'(col_i) - 1'b1;   // window ends at col, starts at col-1
end

endmodule

`default_nettype wire

// File: src/scan_counters.sv
`timescale 1ns/1ps
`default_nettype none

module scan_counters
#(
	parameter int IMG_W = 6,
	parameter int IMG_H = 4
)
(
	input wire clk,
	input wire n_rst,
	input wire cnt_clr_i,
	input wire col_inc_i,
	input wire row_inc_i,
	input wire out_inc_i,
	output logic [$clog2(IMG_W)-1:0] col_o,
	output logic [$clog2(IMG_H)-1:0] row_o,
	output logic [$clog2(IMG_W)-1:0] out_col_o,
	output logic col_last_o,
	output logic row_last_o,
	output logic out_last_o
);

localparam int COL_W = $clog2(IMG_W);
localparam int ROW_W = $clog2(IMG_H);

assign col_last_o = (col_o == COL_W'(IMG_W - 1));     // right edge of image
assign row_last_o = (row_o == ROW_W'(IMG_H - 1));     // bottom row
assign out_last_o = (out_col_o == COL_W'(IMG_W - 2)); // result row is one narrower

always_ff @(posedge clk, negedge n_rst)
begin
	if (n_rst == 1'b0)
	begin
		col_o <= '0;
		row_o <= '0;
		out_col_o <= '0;
	end
	else if (cnt_clr_i)
	begin
		col_o <= '0;
		row_o <= '0;
		out_col_o <= '0;
	end
	else
	begin
		if (col_inc_i)
			col_o <= col_last_o ? '0 : col_o + 1'b1;
		if (row_inc_i)
			row_o <= row_last_o ? '0 : row_o + 1'b1;
		if (out_inc_i)
			out_col_o <= out_last_o ? '0 : out_col_o + 1'b1;
	end
end

endmodule

`default_nettype wire

// File: src/seq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module seq_ctrl
(
	input wire clk,
	input wire n_rst,
	input wire start_i,
	input wire sdram_valid_i,
	input wire ram_valid_i,
	input wire col_last_i,
	input wire row_last_i,
	input wire out_last_i,
	output logic finish_o,
	output logic sdram_rd_o,
	output logic sdram_wr_o,
	output logic cnt_clr_o,
	output logic col_inc_o,
	output logic row_inc_o,
	output logic out_inc_o,
	output ctrl_pkg::sdram_dir_e sdram_dir_o,
	output logic ram_en_o,
	output logic ram_we_o,
	output ctrl_pkg::ram_region_e ram_region_o,
	output logic wb_en_o,
	output ctrl_pkg::wb_mode_e wb_mode_o
);

import ctrl_pkg::*;

typedef enum logic [3:0] {
	S_IDLE,         // wait for start
	S_FR_RD,        // first row: sdram pixel into row cache
	S_ROW_STEP,     // next row or finish
	S_FC_TL,        // first column: cache into top-left
	S_FC_BL,        // first column: sdram into bottom-left and cache
	S_AC_TR,        // any column: cache into top-right
	S_AC_BR,        // any column: sdram into bottom-right and cache
	S_AC_STORE,     // gradient into output row
	S_AC_SHIFT,     // slide window, next column
	S_WB_RD,        // output row read
	S_WB_WR,        // result into sdram
	S_FINISH
} state_e;

state_e state;
state_e next_state;
logic pend_q;       // request issued, valid still due
logic sd_wait;      // state waits on an sdram read
logic ram_wait;     // state waits on a line ram read
logic done;         // awaited read is back this cycle

assign sd_wait = (state == S_FR_RD) || (state == S_FC_BL) || (state == S_AC_BR);
assign ram_wait = (state == S_FC_TL) || (state == S_AC_TR) || (state == S_WB_RD);
assign done = (sd_wait && sdram_valid_i) || (ram_wait && ram_valid_i);
assign sdram_rd_o = sd_wait && !pend_q;  // single cycle, first cycle of the wait

always_ff @(posedge clk, negedge n_rst)
begin
	if (n_rst == 1'b0)
	begin
		state <= S_IDLE;
		pend_q <= 1'b0;
	end
	else
	begin
		state <= next_state;
		pend_q <= (sd_wait || ram_wait) && !done; // cleared so a looping state asks again
	end
end

always_comb
begin
	next_state = state;
	finish_o = 1'b0;
	sdram_wr_o = 1'b0;
	cnt_clr_o = 1'b0;
	col_inc_o = 1'b0;
	row_inc_o = 1'b0;
	out_inc_o = 1'b0;
	sdram_dir_o = RD_IMAGE;
	ram_en_o = ram_wait && !pend_q;  // line ram read request
	ram_we_o = 1'b0;
	ram_region_o = ROW_CACHE;
	wb_en_o = 1'b0;
	wb_mode_o = LD_TL;
	case (state)
		S_IDLE:
		begin
			cnt_clr_o = start_i;     // a second run starts from pixel 0
			next_state = start_i ? S_FR_RD : S_IDLE;
		end
		S_FR_RD:
		begin
			ram_en_o = done;         // pixel written as it arrives
			ram_we_o = done;
			col_inc_o = done;
			if (done)
				next_state = col_last_i ? S_ROW_STEP : S_FR_RD;
		end
		S_ROW_STEP:
		begin
			row_inc_o = 1'b1;        // wraps to 0 after the last row
			next_state = row_last_i ? S_FINISH : S_FC_TL;
		end
		S_FC_TL:
		begin
			wb_en_o = done;
			next_state = done ? S_FC_BL : S_FC_TL;
		end
		S_FC_BL:
		begin
			wb_mode_o = LD_BL;
			wb_en_o = done;
			ram_en_o = done;         // cache now holds this row at col 0
			ram_we_o = done;
			col_inc_o = done;
			next_state = done ? S_AC_TR : S_FC_BL;
		end
		S_AC_TR:
		begin
			wb_mode_o = LD_TR;
			wb_en_o = done;
			next_state = done ? S_AC_BR : S_AC_TR;
		end
		S_AC_BR:
		begin
			wb_mode_o = LD_BR;
			wb_en_o = done;
			ram_en_o = done;         // refresh cache after top-right was taken
			ram_we_o = done;
			next_state = done ? S_AC_STORE : S_AC_BR;
		end
		S_AC_STORE:
		begin
			ram_en_o = 1'b1;
			ram_we_o = 1'b1;
			ram_region_o = OUT_ROW;
			next_state = S_AC_SHIFT;
		end
		S_AC_SHIFT:
		begin
			wb_mode_o = SHIFT;
			wb_en_o = 1'b1;
			col_inc_o = 1'b1;
			next_state = col_last_i ? S_WB_RD : S_AC_TR;
		end
		S_WB_RD:
		begin
			sdram_dir_o = WR_RESULT; // selects read-back address in line ram
			ram_region_o = OUT_ROW;
			next_state = done ? S_WB_WR : S_WB_RD;
		end
		S_WB_WR:
		begin
			sdram_wr_o = 1'b1;       // ram data held since the read
			sdram_dir_o = WR_RESULT;
			ram_region_o = OUT_ROW;
			out_inc_o = 1'b1;
			next_state = out_last_i ? S_ROW_STEP : S_WB_RD;
		end
		S_FINISH:
		begin
			finish_o = 1'b1;
			next_state = S_IDLE;
		end
		default: next_state = S_IDLE;
	endcase
end

endmodule

`default_nettype wire

// File: src/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

// window positions
//   TL TR
//   BL BR
typedef enum logic [2:0] {
	LD_TL = 3'd1,   // previous row, left, from row cache
	LD_TR = 3'd2,   // previous row, right, from row cache
	LD_BL = 3'd3,   // current row, left, straight from sdram
	LD_BR = 3'd4,   // current row, right, straight from sdram
	SHIFT = 3'd5    // right column into left column
} wb_mode_e;

typedef enum logic {
	OUT_ROW   = 1'b0,   // gradient row awaiting write-back
	ROW_CACHE = 1'b1    // copy of the previous image row
} ram_region_e;

typedef enum logic {
	WR_RESULT = 1'b0,   // result image address
	RD_IMAGE  = 1'b1    // source image address
} sdram_dir_e;

endpackage

`default_nettype wire

// File: src/img_pkg.sv
`default_nettype none

package img_pkg;

localparam int PIX_W = 8;                     // grayscale depth
typedef logic [PIX_W-1:0] pix_t;              // one image or result pixel
localparam pix_t PIX_MAX = 8'd255;            // gradient clips here

localparam int SDRAM_AW = 16;                 // word addressed, one pixel per word
typedef logic [SDRAM_AW-1:0] sdram_addr_t;

endpackage

`default_nettype wire
